/* src/rf_ctrl_pkg.sv */
`default_nettype none

package rf_ctrl_pkg;

    typedef logic [7:0] byte_t;                 // One UART data byte

    // Host command codes
    localparam byte_t CMD_SAVE_CFG = 8'hC0;
    localparam byte_t CMD_LOAD_CFG = 8'hC2;
    localparam byte_t CMD_READ_CFG = 8'hC1;
    localparam byte_t CMD_READ_VER = 8'hC3;
    localparam byte_t CMD_RESET    = 8'hC4;

    // Version reply bytes in transmit order
    localparam byte_t VERSION_0 = 8'hC3;
    localparam byte_t VERSION_1 = 8'h32;
    localparam byte_t VERSION_2 = 8'h27;
    localparam byte_t VERSION_3 = 8'h02;

    localparam byte_t CFG_SPED_INIT = 8'h18;    // 8N1 at 9600 baud

    localparam int CFG_LEN     = 6;
    localparam int VERSION_LEN = 4;
    typedef logic [2:0] reply_idx_t;            // Byte position inside a reply

    // Transparent mode buffering
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;     // 0 to FIFO_DEPTH

    localparam int TX_START_LEVEL      = 58;
    localparam int IDLE_TIMEOUT_CYCLES = 200;
    localparam int IDLE_CNT_W          = $clog2(IDLE_TIMEOUT_CYCLES + 1);
    typedef logic [IDLE_CNT_W-1:0] idle_cnt_t;

    typedef enum logic [1:0] {                  // {m1, m0}
        MODE_NORMAL = 2'd0,
        MODE_WAKE   = 2'd1,
        MODE_SAVE   = 2'd2,
        MODE_CONFIG = 2'd3
    } op_mode_t;

    typedef enum logic {
        REPLY_CONFIG  = 1'b0,
        REPLY_VERSION = 1'b1
    } reply_kind_t;

    typedef enum logic [3:0] {
        P_IDLE, P_ADDH, P_ADDL, P_SPED, P_CHAN, P_OPTION,
        P_CFG2, P_CFG3, P_VER2, P_VER3
    } parser_state_t;

    typedef enum logic [1:0] {
        AIR_IDLE, AIR_WAIT, AIR_SEND
    } air_state_t;

endpackage

`default_nettype wire

/* src/cfg_if.sv */
`default_nettype none

// Six configuration registers shared by the parser and the reply path
interface cfg_if import rf_ctrl_pkg::*; ();

    byte_t head;
    byte_t addh;                                // Module address high
    byte_t addl;                                // Module address low
    byte_t sped;                                // Host UART format and baud
    byte_t chan;                                // Radio channel
    byte_t option;

    // Parser owns and updates the registers
    modport owner (
        output head, addh, addl, sped, chan, option
    );

    // Reply generator only reads them back
    modport reader (
        input head, addh, addl, sped, chan, option
    );

endinterface

`default_nettype wire

/* src/cmd_parser.sv */
`default_nettype none

module cmd_parser import rf_ctrl_pkg::*; (
    input  logic        internal_clk,
    input  logic        rst_n,
    input  logic        rx_valid,
    input  byte_t       rx_data,
    input  logic        reply_busy,
    cfg_if.owner        cfg,
    output logic        reply_start,
    output reply_kind_t reply_kind
);

    parser_state_t state;

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= P_IDLE;
            reply_start <= 1'b0;
            reply_kind  <= REPLY_CONFIG;
            cfg.head    <= '0;
            cfg.addh    <= '0;
            cfg.addl    <= '0;
            cfg.sped    <= CFG_SPED_INIT;
            cfg.chan    <= '0;
            cfg.option  <= '0;
        end else begin
            reply_start <= 1'b0;                // Single cycle pulse
            if (rx_valid) begin
                case (state)
                    P_IDLE: begin
                        case (rx_data)
                            CMD_SAVE_CFG, CMD_LOAD_CFG: begin
                                cfg.head <= rx_data;
                                state    <= P_ADDH;
                            end
                            CMD_READ_CFG: state <= P_CFG2;
                            CMD_READ_VER: state <= P_VER2;
                            default:      state <= P_IDLE;
                        endcase
                    end
                    // Write sequence stores one register per byte
                    P_ADDH: begin
                        cfg.addh <= rx_data;
                        state    <= P_ADDL;
                    end
                    P_ADDL: begin
                        cfg.addl <= rx_data;
                        state    <= P_SPED;
                    end
                    P_SPED: begin
                        cfg.sped <= rx_data;
                        state    <= P_CHAN;
                    end
                    P_CHAN: begin
                        cfg.chan <= rx_data;
                        state    <= P_OPTION;
                    end
                    P_OPTION: begin
                        cfg.option <= rx_data;
                        state      <= P_IDLE;
                    end
                    // Read triples abort on any other byte
                    P_CFG2: state <= (rx_data == CMD_READ_CFG) ? P_CFG3 : P_IDLE;
                    P_CFG3: begin
                        state <= P_IDLE;
                        if (rx_data == CMD_READ_CFG && !reply_busy) begin
                            reply_start <= 1'b1;
                            reply_kind  <= REPLY_CONFIG;
                        end
                    end
                    P_VER2: state <= (rx_data == CMD_READ_VER) ? P_VER3 : P_IDLE;
                    P_VER3: begin
                        state <= P_IDLE;
                        if (rx_data == CMD_READ_VER && !reply_busy) begin
                            reply_start <= 1'b1;
                            reply_kind  <= REPLY_VERSION;
                        end
                    end
                    default: state <= P_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/reply_gen.sv */
`default_nettype none

module reply_gen import rf_ctrl_pkg::*; (
    input  logic        internal_clk,
    input  logic        rst_n,
    cfg_if.reader       cfg,
    input  logic        reply_start,
    input  reply_kind_t reply_kind,
    input  logic        tx_ready,
    output logic        tx_valid,
    output byte_t       tx_data,
    output logic        reply_busy
);

    logic        sending;
    reply_kind_t kind_q;
    reply_idx_t  idx;
    reply_idx_t  last_idx;

    assign last_idx = (kind_q == REPLY_VERSION) ? reply_idx_t'(VERSION_LEN - 1)
                                                : reply_idx_t'(CFG_LEN - 1);

    assign tx_valid   = sending;
    assign reply_busy = sending | reply_start;  // Covers the start cycle too

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            sending <= 1'b0;
            kind_q  <= REPLY_CONFIG;
            idx     <= '0;
        end else if (reply_start) begin
            sending <= 1'b1;
            kind_q  <= reply_kind;
            idx     <= '0;
        end else if (sending && tx_ready) begin
            if (idx == last_idx)
                sending <= 1'b0;                // Last byte accepted
            else
                idx <= idx + reply_idx_t'(1);
        end
    end

    // Byte select
    always_comb begin
        tx_data = '0;
        if (kind_q == REPLY_VERSION) begin
            case (idx)
                3'd0:    tx_data = VERSION_0;
                3'd1:    tx_data = VERSION_1;
                3'd2:    tx_data = VERSION_2;
                3'd3:    tx_data = VERSION_3;
                default: tx_data = '0;
            endcase
        end else begin
            case (idx)
                3'd0:    tx_data = cfg.head;
                3'd1:    tx_data = cfg.addh;
                3'd2:    tx_data = cfg.addl;
                3'd3:    tx_data = cfg.sped;
                3'd4:    tx_data = cfg.chan;
                3'd5:    tx_data = cfg.option;
                default: tx_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/tx_fifo.sv */
`default_nettype none

module tx_fifo import rf_ctrl_pkg::*; (
    input  logic      internal_clk,
    input  logic      rst_n,
    input  logic      push,
    input  byte_t     wr_data,
    input  logic      pop,
    output byte_t     rd_data,
    output fifo_cnt_t count,
    output logic      empty,
    output logic      full
);

    byte_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_push;
    logic      do_pop;

    assign do_push = push && !full;             // Dropped when full
    assign do_pop  = pop && !empty;

    assign empty   = (count == '0);
    assign full    = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign rd_data = mem[rd_ptr];               // Head entry without read latency

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at FIFO_DEPTH on their own
            if (do_push)
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            count <= count + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
        end
    end

    always_ff @(posedge internal_clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* src/air_tx_ctrl.sv */
`default_nettype none

module air_tx_ctrl import rf_ctrl_pkg::*; (
    input  logic      internal_clk,
    input  logic      rst_n,
    input  logic      host_byte,
    input  fifo_cnt_t count,
    input  logic      empty,
    input  logic      node_tx_ready,
    output logic      node_tx_valid,
    output logic      pop,
    output logic      idle
);

    air_state_t state;
    idle_cnt_t  silence;                        // Cycles since last host byte
    logic       timed_out;
    logic       level_hit;

    assign timed_out = (silence == idle_cnt_t'(IDLE_TIMEOUT_CYCLES));
    assign level_hit = (count >= fifo_cnt_t'(TX_START_LEVEL));

    assign node_tx_valid = (state == AIR_SEND) && !empty;
    assign pop           = node_tx_valid && node_tx_ready;
    assign idle          = (state == AIR_IDLE);

    // Saturating silence counter
    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n)
            silence <= idle_cnt_t'(IDLE_TIMEOUT_CYCLES);
        else if (host_byte)
            silence <= '0;
        else if (!timed_out)
            silence <= silence + idle_cnt_t'(1);
    end

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= AIR_IDLE;
        end else begin
            case (state)
                AIR_IDLE: if (!empty) state <= AIR_WAIT;
                AIR_WAIT: begin
                    // Full packet, or a short one after the host goes quiet
                    if (level_hit || timed_out)
                        state <= AIR_SEND;
                end
                AIR_SEND: if (empty) state <= AIR_IDLE;
                default:  state <= AIR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/rf_ctrl_top.sv */
`default_nettype none

module rf_ctrl_top import rf_ctrl_pkg::*; (
    input  logic  internal_clk,
    input  logic  rst_n,
    input  logic  m0,
    input  logic  m1,
    input  logic  mcu_rx_valid,
    input  byte_t mcu_rx_data,
    input  logic  mcu_tx_ready,
    input  logic  node_tx_ready,
    output logic  mcu_tx_valid,
    output byte_t mcu_tx_data,
    output byte_t uart_cfg,
    output logic  node_tx_valid,
    output byte_t node_tx_data,
    output logic  aux
);

    op_mode_t    mode;
    logic        cfg_byte;
    logic        push;
    logic        reply_start;
    reply_kind_t reply_kind;
    logic        reply_busy;
    logic        pop;
    fifo_cnt_t   count;
    logic        empty;
    logic        full;
    logic        air_idle;

    cfg_if cfg_bus ();

    assign mode     = op_mode_t'({m1, m0});
    assign cfg_byte = mcu_rx_valid && (mode == MODE_CONFIG);
    assign push     = mcu_rx_valid && (mode == MODE_NORMAL);  // Wake and save modes drop bytes

    assign uart_cfg = cfg_bus.sped;
    assign aux      = !reply_busy && air_idle;  // Low while anything is pending

    cmd_parser cmd_parser_i (
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .rx_valid     (cfg_byte),
        .rx_data      (mcu_rx_data),
        .reply_busy   (reply_busy),
        .cfg          (cfg_bus.owner),
        .reply_start  (reply_start),
        .reply_kind   (reply_kind)
    );

    reply_gen reply_gen_i (
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .cfg          (cfg_bus.reader),
        .reply_start  (reply_start),
        .reply_kind   (reply_kind),
        .tx_ready     (mcu_tx_ready),
        .tx_valid     (mcu_tx_valid),
        .tx_data      (mcu_tx_data),
        .reply_busy   (reply_busy)
    );

    tx_fifo tx_fifo_i (
        .internal_clk (internal_clk),
        .rst_n        (rst_n),
        .push         (push),
        .wr_data      (mcu_rx_data),
        .pop          (pop),
        .rd_data      (node_tx_data),
        .count        (count),
        .empty        (empty),
        .full         (full)
    );

    air_tx_ctrl air_tx_ctrl_i (
        .internal_clk  (internal_clk),
        .rst_n         (rst_n),
        .host_byte     (push && !full),
        .count         (count),
        .empty         (empty),
        .node_tx_ready (node_tx_ready),
        .node_tx_valid (node_tx_valid),
        .pop           (pop),
        .idle          (air_idle)
    );

endmodule

`default_nettype wire

/* verif/tb_rf_ctrl.sv */
`default_nettype none

module tb_rf_ctrl import rf_ctrl_pkg::*; ();

    localparam int        TOTAL_BYTES = 112;    // Host bytes sent over all tests
    localparam fifo_cnt_t BURST_LEN   = 80;
    localparam int        SHORT_LEN   = 10;

    logic  internal_clk, rst_n, m0, m1;
    logic  mcu_rx_valid, mcu_tx_ready, node_tx_ready;
    logic  mcu_tx_valid, node_tx_valid, aux;
    byte_t mcu_rx_data, mcu_tx_data, uart_cfg, node_tx_data;

    logic [31:0] lfsr;
    logic        rand_ready;
    string       cur_test;
    int          checks, errors, test_errors, tests;

    byte_t model_cfg [CFG_LEN];                 // Reference copy of the registers
    int    wr_pos;                              // Next field of a write or 0
    int    rd_run;
    byte_t rd_cmd;
    byte_t exp_host [$];
    byte_t exp_node [$];

    rf_ctrl_top rf_ctrl_top_i (.*);

    initial internal_clk = 1'b0;
    always #50 internal_clk = ~internal_clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic byte_t rand_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    // Expected host reply or radio bytes for one host byte
    function automatic void predict(input op_mode_t mode, input byte_t b);
        if (mode == MODE_NORMAL) begin
            exp_node.push_back(b);
        end else if (mode == MODE_CONFIG) begin
            if (wr_pos != 0) begin
                model_cfg[wr_pos] = b;
                wr_pos = (wr_pos == CFG_LEN - 1) ? 0 : wr_pos + 1;
            end else if (rd_run != 0) begin
                rd_run = (b == rd_cmd) ? rd_run + 1 : 0;   // Wrong byte breaks the triple
                if (rd_run == 3) begin
                    rd_run = 0;
                    if (rd_cmd == CMD_READ_CFG) begin
                        for (int i = 0; i < CFG_LEN; i++)
                            exp_host.push_back(model_cfg[i]);
                    end else begin
                        exp_host.push_back(VERSION_0);
                        exp_host.push_back(VERSION_1);
                        exp_host.push_back(VERSION_2);
                        exp_host.push_back(VERSION_3);
                    end
                end
            end else if (b == CMD_SAVE_CFG || b == CMD_LOAD_CFG) begin
                model_cfg[0] = b;
                wr_pos = 1;
            end else if (b == CMD_READ_CFG || b == CMD_READ_VER) begin
                rd_cmd = b;
                rd_run = 1;
            end
        end
    endfunction

    task automatic check_byte(input string what, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // Every accepted output byte against the model in order
    always @(posedge internal_clk) begin
        if (rst_n && mcu_tx_valid && mcu_tx_ready) begin
            if (exp_host.size() == 0) begin
                errors++;
                $display("%s: unexpected byte %h sent to the host", cur_test, mcu_tx_data);
            end else
                check_byte("host byte", exp_host.pop_front(), mcu_tx_data);
            check_bit("aux during reply", 1'b0, aux);
        end
        if (rst_n && node_tx_valid && node_tx_ready) begin
            if (exp_node.size() == 0) begin
                errors++;
                $display("%s: unexpected byte %h sent to the radio", cur_test, node_tx_data);
            end else
                check_byte("radio byte", exp_node.pop_front(), node_tx_data);
            check_bit("aux during send", 1'b0, aux);
        end
    end

    task automatic tick();
        @(negedge internal_clk);
        if (rand_ready) begin
            mcu_tx_ready  = lfsr_bit();
            node_tx_ready = lfsr_bit();
        end
    endtask

    task automatic send(input byte_t b);
        tick();
        mcu_rx_valid = 1'b1;
        mcu_rx_data  = b;
        predict(op_mode_t'({m1, m0}), b);
    endtask

    task automatic end_burst();
        tick();
        mcu_rx_valid = 1'b0;
    endtask

    task automatic set_mode(input op_mode_t mode);
        tick();
        {m1, m0} = mode;
    endtask

    // Until every expected byte is out and aux is back high
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_host.size() != 0 || exp_node.size() != 0 || !aux) && n < limit) begin
            tick();
            n++;
        end
        if (exp_host.size() != 0 || exp_node.size() != 0 || !aux) begin
            errors++;
            $display("%s: timed out with %0d host and %0d radio bytes missing, aux %b",
                     cur_test, exp_host.size(), exp_node.size(), aux);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%-18s %s", cur_test, (errors == test_errors) ? "passed" : "failed");
    endtask

    initial begin
        lfsr       = 32'hacb1_465d;
        rand_ready = 1'b0;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        wr_pos     = 0;
        rd_run     = 0;
        cur_test   = "startup";
        rd_cmd     = '0;
        foreach (model_cfg[i])
            model_cfg[i] = '0;
        model_cfg[3] = 8'h18;
        m1            = 1'b0;
        m0            = 1'b0;
        mcu_rx_valid  = 1'b0;
        mcu_rx_data   = '0;
        mcu_tx_ready  = 1'b1;
        node_tx_ready = 1'b1;
        rst_n         = 1'b0;
        repeat (4) @(posedge internal_clk);
        @(negedge internal_clk);
        rst_n = 1'b1;

        begin_test("reset_values");
        tick();
        check_bit("aux", 1'b1, aux);
        check_bit("mcu_tx_valid", 1'b0, mcu_tx_valid);
        check_bit("node_tx_valid", 1'b0, node_tx_valid);
        check_byte("uart_cfg", 8'h18, uart_cfg);
        end_test();

        begin_test("config_write_read");
        set_mode(MODE_CONFIG);
        rand_ready = 1'b1;
        send(CMD_SAVE_CFG);
        for (int i = 1; i < CFG_LEN; i++)
            send(rand_byte());
        end_burst();
        check_byte("uart_cfg", model_cfg[3], uart_cfg);   // SPED field
        repeat (3) send(CMD_READ_CFG);
        end_burst();
        wait_drained(100);
        end_test();

        begin_test("version_read");
        repeat (3) send(CMD_READ_VER);
        end_burst();
        wait_drained(100);
        check_bit("aux after reply", 1'b1, aux);
        end_test();

        begin_test("ignored_commands");
        send(CMD_RESET);
        send(CMD_READ_CFG);
        send(CMD_READ_CFG);
        send(8'h55);
        end_burst();
        set_mode(MODE_SAVE);
        repeat (3) send(CMD_READ_VER);          // Dropped outside config mode
        end_burst();
        set_mode(MODE_CONFIG);
        repeat (20) tick();
        check_bit("mcu_tx_valid", 1'b0, mcu_tx_valid);
        repeat (3) send(CMD_READ_CFG);
        end_burst();
        wait_drained(100);
        end_test();

        begin_test("threshold_release");
        set_mode(MODE_NORMAL);
        for (int i = 0; i < int'(BURST_LEN); i++)
            send(rand_byte());
        end_burst();
        check_bit("aux while pending", 1'b0, aux);
        check_bit("node_tx_valid at burst end", 1'b1, node_tx_valid);   // Level reached
        wait_drained(int'(BURST_LEN) * 5);
        end_test();

        begin_test("timeout_release");
        for (int i = 0; i < SHORT_LEN; i++)
            send(rand_byte());
        end_burst();
        check_bit("node_tx_valid before timeout", 1'b0, node_tx_valid);
        wait_drained(IDLE_TIMEOUT_CYCLES + 5 * SHORT_LEN + 20);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        repeat (TOTAL_BYTES * (IDLE_TIMEOUT_CYCLES + 20)) @(posedge internal_clk);
        $display("watchdog expired during %s, the run did not finish", cur_test);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/rf_ctrl_pkg.sv
src/cfg_if.sv
src/cmd_parser.sv
src/reply_gen.sv
src/tx_fifo.sv
src/air_tx_ctrl.sv
src/rf_ctrl_top.sv
verif/tb_rf_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the rf_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_rf_ctrl -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
exit 1
